//--- Bender.yml
package:
  name: div_unit

sources:
  - div_pkg.sv
  - div_operands_if.sv
  - div_raw_if.sv
  - div_prepare.sv
  - div_kernel.sv
  - div_fix.sv
  - div_unit.sv
  - target: test
    files:
      - tb_div_unit.sv

//--- div_fix.sv
`default_nettype none

module div_fix
  import div_pkg::*;
#(
  parameter int WIDTH = DEFAULT_WIDTH
) (
  input  logic             clk,
  input  logic             rst_n,
  div_raw_if.fix           raw,
  output logic [WIDTH-1:0] result_o,
  output logic             done_o,
  output logic             div_by_zero_o,
  output logic             div_overflow_o
);

  logic [WIDTH-1:0] quo_fixed;
  logic [WIDTH-1:0] rem_fixed;

  // sign restore
  assign quo_fixed = raw.neg_q ? -raw.quotient : raw.quotient;
  assign rem_fixed = raw.neg_r ? -raw.remainder : raw.remainder;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result_o       <= '0;
      done_o         <= 1'b0;
      div_by_zero_o  <= 1'b0;
      div_overflow_o <= 1'b0;
    end else begin
      // flags only pulse with done
      done_o         <= raw.ready;
      div_by_zero_o  <= raw.ready && raw.by_zero;
      div_overflow_o <= raw.ready && raw.overflow;
      if (raw.ready) begin
        result_o <= raw.want_rem ? rem_fixed : quo_fixed; // held until next done
      end
    end
  end

endmodule

`default_nettype wire

//--- div_kernel.sv
`default_nettype none

module div_kernel
  import div_pkg::*;
#(
  parameter int WIDTH = DEFAULT_WIDTH
) (
  input  logic           clk,
  input  logic           rst_n,
  div_operands_if.kernel ops,
  div_raw_if.kernel      raw
);

  localparam int CNT_W = $clog2(WIDTH);

  logic             running_q;
  logic             ready_q;
  logic [CNT_W-1:0] count_q;
  logic             last_iter;
  logic             special;

  logic [WIDTH:0]   rem_q;   // partial remainder, one bit extra
  logic [WIDTH-1:0] quo_q;   // dividend bits out, quotient bits in
  logic [WIDTH-1:0] divisor_q;
  logic             neg_q_q;
  logic             neg_r_q;
  logic             want_rem_q;
  logic             by_zero_q;
  logic             overflow_q;

  logic [WIDTH:0]   shifted;
  logic [WIDTH:0]   trial;

  assign special = ops.by_zero || ops.overflow;
  assign last_iter = (count_q == CNT_W'(WIDTH - 1));

  // bring in next dividend bit, then trial subtract
  assign shifted = {rem_q[WIDTH-1:0], quo_q[WIDTH-1]};
  assign trial = shifted - {1'b0, divisor_q};
  // trial[WIDTH] set means the difference went negative

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      running_q <= 1'b0;
      ready_q   <= 1'b0;
      count_q   <= '0;
    end else begin
      ready_q <= 1'b0;
      if (ops.start) begin
        running_q <= !special;
        ready_q   <= special; // special cases skip iterations
        count_q   <= '0;
      end else if (running_q) begin
        count_q <= count_q + 1'b1;
        if (last_iter) begin
          running_q <= 1'b0;
          ready_q   <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ops.start) begin
      divisor_q  <= ops.divisor;
      neg_q_q    <= ops.neg_q;
      neg_r_q    <= ops.neg_r;
      want_rem_q <= ops.want_rem;
      by_zero_q  <= ops.by_zero;
      overflow_q <= ops.overflow;
      if (ops.by_zero) begin
        quo_q <= '1;
        rem_q <= {1'b0, ops.dividend};
      end else begin
        // also the overflow result: q = dividend, r = 0
        quo_q <= ops.dividend;
        rem_q <= '0;
      end
    end else if (running_q) begin
      quo_q <= {quo_q[WIDTH-2:0], ~trial[WIDTH]};
      rem_q <= trial[WIDTH] ? shifted : trial; // restore on negative
    end
  end

  assign raw.ready     = ready_q;
  assign raw.quotient  = quo_q;
  assign raw.remainder = rem_q[WIDTH-1:0];
  assign raw.neg_q     = neg_q_q;
  assign raw.neg_r     = neg_r_q;
  assign raw.want_rem  = want_rem_q;
  assign raw.by_zero   = by_zero_q;
  assign raw.overflow  = overflow_q;

endmodule

`default_nettype wire

//--- div_operands_if.sv
`default_nettype none

// prepare -> kernel, fields valid only while start is high
interface div_operands_if
  import div_pkg::*;
#(
  parameter int WIDTH = DEFAULT_WIDTH
) ();

  logic             start;
  logic             by_zero;
  logic             overflow;
  logic [WIDTH-1:0] dividend; // magnitude, or raw on special case
  logic [WIDTH-1:0] divisor;
  logic             neg_q;
  logic             neg_r;
  logic             want_rem;

  modport prep (
    output start, by_zero, overflow, dividend, divisor, neg_q, neg_r, want_rem
  );

  modport kernel (
    input start, by_zero, overflow, dividend, divisor, neg_q, neg_r, want_rem
  );

endinterface

`default_nettype wire

//--- div_pkg.sv
`default_nettype none

package div_pkg;

  localparam int DEFAULT_WIDTH = 32;

  // bit positions inside the op code
  localparam int OP_UNSIGNED_BIT = 0;
  localparam int OP_REM_BIT = 1;

  typedef enum logic [1:0] {
    OP_DIV  = 2'b00, // signed quotient
    OP_DIVU = 2'b01,
    OP_REM  = 2'b10, // signed remainder
    OP_REMU = 2'b11
  } div_op_t;

endpackage

`default_nettype wire

//--- div_prepare.sv
`default_nettype none

module div_prepare
  import div_pkg::*;
#(
  parameter int WIDTH = DEFAULT_WIDTH
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               valid_i,
  input  div_op_t            op_i,
  input  logic [WIDTH-1:0]   dividend_i,
  input  logic [WIDTH-1:0]   divisor_i,
  input  logic               done_i,
  div_operands_if.prep       ops
);

  localparam logic [WIDTH-1:0] MOST_NEG = {1'b1, {(WIDTH-1){1'b0}}};

  logic             busy_q;
  logic             accept;
  logic             is_signed;
  logic             dvd_neg;
  logic             dvs_neg;
  logic [WIDTH-1:0] dvd_mag;
  logic [WIDTH-1:0] dvs_mag;
  logic             by_zero;
  logic             overflow;

  assign accept = valid_i && !busy_q; // requests while busy are dropped

  assign is_signed = !op_i[OP_UNSIGNED_BIT];
  assign dvd_neg = is_signed && dividend_i[WIDTH-1];
  assign dvs_neg = is_signed && divisor_i[WIDTH-1];

  assign dvd_mag = dvd_neg ? -dividend_i : dividend_i;
  assign dvs_mag = dvs_neg ? -divisor_i : divisor_i;

  assign by_zero = (divisor_i == '0);
  // MIN / -1 does not fit
  assign overflow = is_signed && (dividend_i == MOST_NEG) && (divisor_i == '1);

  // busy from acceptance until the done cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy_q    <= 1'b0;
      ops.start <= 1'b0;
    end else begin
      ops.start <= accept;
      if (accept) begin
        busy_q <= 1'b1;
      end else if (done_i) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      ops.by_zero  <= by_zero;
      ops.overflow <= overflow;
      ops.divisor  <= dvs_mag;
      ops.want_rem <= op_i[OP_REM_BIT];
      if (by_zero || overflow) begin
        ops.dividend <= dividend_i; // kernel forwards it as is
        ops.neg_q    <= 1'b0;
        ops.neg_r    <= 1'b0;
      end else begin
        ops.dividend <= dvd_mag;
        ops.neg_q    <= dvd_neg ^ dvs_neg;
        ops.neg_r    <= dvd_neg;
      end
    end
  end

endmodule

`default_nettype wire

//--- div_raw_if.sv
`default_nettype none

// kernel -> fix, fields valid only while ready is high
interface div_raw_if
  import div_pkg::*;
#(
  parameter int WIDTH = DEFAULT_WIDTH
) ();

  logic             ready;
  logic [WIDTH-1:0] quotient;  // unsigned
  logic [WIDTH-1:0] remainder; // unsigned
  logic             neg_q;
  logic             neg_r;
  logic             want_rem;
  logic             by_zero;
  logic             overflow;

  modport kernel (
    output ready, quotient, remainder, neg_q, neg_r, want_rem, by_zero, overflow
  );

  modport fix (
    input ready, quotient, remainder, neg_q, neg_r, want_rem, by_zero, overflow
  );

endinterface

`default_nettype wire

//--- div_unit.f
div_pkg.sv
div_operands_if.sv
div_raw_if.sv
div_prepare.sv
div_kernel.sv
div_fix.sv
div_unit.sv
tb_div_unit.sv

//--- div_unit.sv
`default_nettype none

module div_unit
  import div_pkg::*;
#(
  parameter int WIDTH = DEFAULT_WIDTH
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             valid_i,
  input  div_op_t          op_i,
  input  logic [WIDTH-1:0] dividend_i,
  input  logic [WIDTH-1:0] divisor_i,
  output logic [WIDTH-1:0] result_o,
  output logic             done_o,
  output logic             div_by_zero_o,
  output logic             div_overflow_o
);

  div_operands_if #(.WIDTH(WIDTH)) ops_if ();
  div_raw_if #(.WIDTH(WIDTH)) raw_if ();

  div_prepare #(
    .WIDTH(WIDTH)
  ) u_prepare (
    .clk        (clk),
    .rst_n      (rst_n),
    .valid_i    (valid_i),
    .op_i       (op_i),
    .dividend_i (dividend_i),
    .divisor_i  (divisor_i),
    .done_i     (done_o), // ends the busy period
    .ops        (ops_if.prep)
  );

  div_kernel #(
    .WIDTH(WIDTH)
  ) u_kernel (
    .clk   (clk),
    .rst_n (rst_n),
    .ops   (ops_if.kernel),
    .raw   (raw_if.kernel)
  );

  div_fix #(
    .WIDTH(WIDTH)
  ) u_fix (
    .clk            (clk),
    .rst_n          (rst_n),
    .raw            (raw_if.fix),
    .result_o       (result_o),
    .done_o         (done_o),
    .div_by_zero_o  (div_by_zero_o),
    .div_overflow_o (div_overflow_o)
  );

endmodule

`default_nettype wire

//--- tb_div_unit.sv
`default_nettype none

module tb_div_unit
  import div_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int WIDTH = 32;
  localparam int LAT_NORMAL = WIDTH + 3;
  localparam int LAT_SPECIAL = 3;
  localparam int TIMEOUT = 100;
  localparam logic [31:0] SEED = 32'hc1c4_6734;
  localparam logic [WIDTH-1:0] MOST_NEG = {1'b1, {(WIDTH-1){1'b0}}};
  localparam logic [WIDTH-1:0] MINUS_ONE = '1;

  logic             clk;
  logic             rst_n;
  logic             valid_i;
  div_op_t          op_i;
  logic [WIDTH-1:0] dividend_i;
  logic [WIDTH-1:0] divisor_i;
  logic [WIDTH-1:0] result_o;
  logic             done_o;
  logic             div_by_zero_o;
  logic             div_overflow_o;

  int               value_errors;
  int               timeout_errors;
  logic [31:0]      rng_state;
  logic [WIDTH-1:0] held_result; // last value seen with done_o
  logic [WIDTH-1:0] last_result;
  int               last_latency;
  logic             last_by_zero;
  logic             last_overflow;

  div_unit #(
    .WIDTH(WIDTH)
  ) u_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .valid_i        (valid_i),
    .op_i           (op_i),
    .dividend_i     (dividend_i),
    .divisor_i      (divisor_i),
    .result_o       (result_o),
    .done_o         (done_o),
    .div_by_zero_o  (div_by_zero_o),
    .div_overflow_o (div_overflow_o)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  function automatic logic [31:0] next_random(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [WIDTH-1:0] corner_value(input logic [2:0] sel);
    case (sel)
      3'd0:    return '0;
      3'd1:    return 1;
      3'd2:    return MINUS_ONE;
      3'd3:    return MOST_NEG;
      3'd4:    return ~MOST_NEG; // most positive
      3'd5:    return 2;
      3'd6:    return MOST_NEG + 1;
      default: return MINUS_ONE - 1;
    endcase
  endfunction

  function automatic bit is_signed_op(input div_op_t op);
    return (op == OP_DIV) || (op == OP_REM);
  endfunction

  // truncating division, remainder follows the dividend sign
  function automatic logic [WIDTH-1:0] model_result(input div_op_t op,
                                                    input logic [WIDTH-1:0] a,
                                                    input logic [WIDTH-1:0] b);
    logic [WIDTH-1:0] q;
    logic [WIDTH-1:0] r;
    if (b == '0) begin
      q = '1;
      r = a;
    end else if (is_signed_op(op) && a == MOST_NEG && b == MINUS_ONE) begin
      q = a;
      r = '0;
    end else if (is_signed_op(op)) begin
      q = $signed(a) / $signed(b);
      r = $signed(a) % $signed(b);
    end else begin
      q = a / b;
      r = a % b;
    end
    return (op == OP_REM || op == OP_REMU) ? r : q;
  endfunction

  task automatic draw_operand(output logic [WIDTH-1:0] v);
    logic [4:0] shift;
    rng_state = next_random(rng_state);
    shift = rng_state[7:3]; // spread magnitudes
    if (rng_state[2:0] == 3'd0) begin
      rng_state = next_random(rng_state);
      v = corner_value(rng_state[2:0]);
    end else begin
      rng_state = next_random(rng_state);
      v = rng_state >> shift;
    end
  endtask

  task automatic report_mismatch(input string what);
    value_errors++;
    $display("FAILED at %0t: %s", $time, what);
  endtask

  task automatic check_idle_outputs();
    assert (!done_o && !div_by_zero_o && !div_overflow_o)
      else report_mismatch("done_o or a flag high outside a done cycle");
    assert (result_o == held_result)
      else report_mismatch($sformatf("result_o %h changed, held %h", result_o, held_result));
  endtask

  task automatic check_no_done(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      check_idle_outputs();
    end
  endtask

  task automatic issue_request(input div_op_t op, input logic [WIDTH-1:0] a,
                               input logic [WIDTH-1:0] b);
    @(posedge clk);
    valid_i    <= 1'b1;
    op_i       <= op;
    dividend_i <= a;
    divisor_i  <= b;
  endtask

  // counts edges from the request edge, samples on the falling edge
  task automatic wait_done(input bit inject, output bit ok);
    int n;
    ok = 1'b0;
    n = 0;
    while (!ok && n < TIMEOUT) begin
      @(posedge clk);
      n++;
      if (n == 1) begin
        valid_i <= 1'b0;
      end
      if (inject && n == 5) begin
        valid_i    <= 1'b1; // second request while busy
        op_i       <= OP_DIVU;
        dividend_i <= 32'h0000_0064;
        divisor_i  <= 32'h0000_0007;
      end
      if (inject && n == 7) begin
        valid_i <= 1'b0;
      end
      @(negedge clk);
      if (done_o) begin
        ok = 1'b1;
      end else begin
        check_idle_outputs();
      end
    end
    if (ok) begin
      last_latency  = n;
      last_result   = result_o;
      last_by_zero  = div_by_zero_o;
      last_overflow = div_overflow_o;
      held_result   = result_o;
    end else begin
      timeout_errors++;
      $display("timeout at %0t: done_o did not rise within %0d cycles", $time, TIMEOUT);
    end
  endtask

  task automatic run_check(input div_op_t op, input logic [WIDTH-1:0] a,
                           input logic [WIDTH-1:0] b, input bit inject,
                           output logic [WIDTH-1:0] res);
    logic [WIDTH-1:0] exp_res;
    bit               exp_zero;
    bit               exp_ovf;
    int               exp_lat;
    bit               ok;
    exp_res  = model_result(op, a, b);
    exp_zero = (b == '0);
    exp_ovf  = is_signed_op(op) && a == MOST_NEG && b == MINUS_ONE;
    exp_lat  = (exp_zero || exp_ovf) ? LAT_SPECIAL : LAT_NORMAL;
    issue_request(op, a, b);
    wait_done(inject, ok);
    res = last_result;
    if (ok) begin
      assert (last_result == exp_res)
        else report_mismatch($sformatf("%s %h, %h gave %h, expected %h",
                                       op.name(), a, b, last_result, exp_res));
      assert (last_latency == exp_lat)
        else report_mismatch($sformatf("%s %h, %h took %0d cycles, expected %0d",
                                       op.name(), a, b, last_latency, exp_lat));
      assert (last_by_zero == exp_zero && last_overflow == exp_ovf)
        else report_mismatch($sformatf("%s %h, %h flags %b%b, expected %b%b", op.name(),
                                       a, b, last_by_zero, last_overflow, exp_zero, exp_ovf));
    end
    if (inject) begin
      check_no_done(LAT_NORMAL + 4); // nothing left over from the ignored request
    end else begin
      check_no_done(1); // done and flags last one cycle
    end
  endtask

  initial begin
    logic [WIDTH-1:0] a;
    logic [WIDTH-1:0] b;
    logic [WIDTH-1:0] q;
    logic [WIDTH-1:0] r;
    div_op_t          zero_ops [4];
    value_errors   = 0;
    timeout_errors = 0;
    rng_state      = SEED;
    held_result    = '0;
    rst_n          = 1'b0;
    valid_i        = 1'b0;
    op_i           = OP_DIV;
    dividend_i     = '0;
    divisor_i      = '0;
    zero_ops       = '{OP_DIV, OP_DIVU, OP_REM, OP_REMU};

    for (int i = 0; i < 4; i++) begin
      @(posedge clk);
      if (i == 3) begin
        rst_n <= 1'b1;
      end
      @(negedge clk);
      check_idle_outputs();
    end
    check_no_done(6);

    // unsigned, nonzero divisors
    for (int i = 0; i < 40; i++) begin
      draw_operand(a);
      draw_operand(b);
      if (b == '0) begin
        b = 1;
      end
      run_check((i % 2 == 0) ? OP_DIVU : OP_REMU, a, b, 1'b0, q);
    end

    // signed, sign pattern walks through all four combinations
    for (int i = 0; i < 40; i++) begin
      draw_operand(a);
      draw_operand(b);
      if (a[WIDTH-1] != i[0]) begin
        a = -a;
      end
      if (b[WIDTH-1] != i[1]) begin
        b = -b;
      end
      if (b == '0) begin
        b = i[1] ? MINUS_ONE : 1;
      end
      if (a == MOST_NEG && b == MINUS_ONE) begin
        b = 1;
      end
      run_check(OP_DIV, a, b, 1'b0, q);
      run_check(OP_REM, a, b, 1'b0, r);
      assert (q * b + r == a)
        else report_mismatch($sformatf("q*b+r != a for %h / %h (q %h r %h)", a, b, q, r));
    end

    // divide by zero
    foreach (zero_ops[k]) begin
      run_check(zero_ops[k], 32'h1234_5678, '0, 1'b0, q);
      run_check(zero_ops[k], MOST_NEG, '0, 1'b0, q);
      run_check(zero_ops[k], 32'hffff_ff9c, '0, 1'b0, q);
    end

    // overflow only in signed mode
    run_check(OP_DIV, MOST_NEG, MINUS_ONE, 1'b0, q);
    run_check(OP_REM, MOST_NEG, MINUS_ONE, 1'b0, q);
    run_check(OP_DIVU, MOST_NEG, MINUS_ONE, 1'b0, q);
    run_check(OP_REMU, MOST_NEG, MINUS_ONE, 1'b0, q);

    // request during busy period
    run_check(OP_DIV, 32'hffff_fc18, 32'h0000_0007, 1'b1, q);
    run_check(OP_REMU, 32'h0000_03e8, 32'h0000_0009, 1'b1, q);

    $display("error counts: %0d wrong values, %0d timeouts", value_errors, timeout_errors);
    if (value_errors == 0 && timeout_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
